/* Makefile */
SRCS := src/rsa_cfg.svh src/rsa_pkg.sv src/mont_mul.sv src/mod_exp.sv \
        src/operand_bank.sv src/cmd_ctrl.sv src/rsa_top.sv tests/tb_rsa_top.sv

.PHONY: run clean

obj_dir/Vtb_rsa_top: $(SRCS) vlog.f
	verilator --binary -f vlog.f --top-module tb_rsa_top -j 0

run: obj_dir/Vtb_rsa_top
	./obj_dir/Vtb_rsa_top | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* src/cmd_ctrl.sv */
`timescale 1ns/1ps
`include "rsa_cfg.svh"

module cmd_ctrl import rsa_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [`RSA_CMDW-1:0] cmd,
    input  logic                 cmd_valid,
    input  logic                 in_valid,
    input  logic                 out_ready,
    input  logic                 done_read,
    output logic                 in_ready,
    output logic                 out_valid,
    output logic                 done,
    output load_sel_e            load_sel,
    output logic                 start,
    output logic                 mode,
    input  logic                 result_valid
);

    typedef enum logic [2:0] {C_IDLE, C_LOAD, C_COMPUTE, C_SEND, C_DONE} ctrl_state_e;

    ctrl_state_e state;
    cmd_op_e     op;
    load_sel_e   ld_kind;

    assign op = cmd_op_e'(cmd[2:0]);

    // Bank captures data_in in the same cycle as the transfer
    assign load_sel = (state == C_LOAD && in_valid && in_ready) ? ld_kind : LOAD_NONE;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= C_IDLE;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
            done      <= 1'b0;
            start     <= 1'b0;
            mode      <= 1'b0;
            ld_kind   <= LOAD_NONE;
        end else begin
            start <= 1'b0;
            case (state)
                C_IDLE: if (cmd_valid) begin
                    case (op)
                        COMPUTE_EXP, COMPUTE_MONT: begin
                            start <= 1'b1;
                            mode  <= (op == COMPUTE_MONT);
                            state <= C_COMPUTE;
                        end
                        READ_MOD: begin
                            ld_kind  <= LOAD_MOD;
                            in_ready <= 1'b1;
                            state    <= C_LOAD;
                        end
                        READ_RSQ: begin
                            ld_kind  <= LOAD_RSQ;
                            in_ready <= 1'b1;
                            state    <= C_LOAD;
                        end
                        READ_EXP: begin
                            ld_kind  <= LOAD_EXP;
                            in_ready <= 1'b1;
                            state    <= C_LOAD;
                        end
                        WRITE_RES: begin
                            out_valid <= 1'b1;
                            state     <= C_SEND;
                        end
                        // Unassigned opcodes are dropped
                        default: ;
                    endcase
                end
                C_LOAD: if (in_valid && in_ready) begin
                    in_ready <= 1'b0;
                    done     <= 1'b1;
                    state    <= C_DONE;
                end
                C_COMPUTE: if (result_valid) begin
                    done  <= 1'b1;
                    state <= C_DONE;
                end
                // out_valid holds until the host takes the word
                C_SEND: if (out_ready) begin
                    out_valid <= 1'b0;
                    done      <= 1'b1;
                    state     <= C_DONE;
                end
                C_DONE: if (done_read) begin
                    done  <= 1'b0;
                    state <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

/* src/mod_exp.sv */
`timescale 1ns/1ps
`include "rsa_cfg.svh"

module mod_exp import rsa_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  logic          mode,
    input  rsa_operands_t ops,
    output logic          result_valid,
    output operand_t      result_value
);

    localparam int OPW = `RSA_OPW;
    localparam int CW  = $clog2(OPW + 1);

    typedef enum logic [2:0] {S_IDLE, S_CONV, S_SCAN, S_SQR, S_MUL, S_FINAL} state_e;

    state_e        state;
    logic          mode_r;
    logic          started;
    logic [CW-1:0] bits_left;
    operand_t      e_sh;
    operand_t      xt;
    operand_t      acc_a;
    logic          adv;

    logic          mm_start;
    operand_t      mm_a;
    operand_t      mm_b;
    logic          mm_done;
    operand_t      mm_product;

    mont_mul i_mul (
        .clk     (clk),
        .resetn  (resetn),
        .start   (mm_start),
        .a       (mm_a),
        .b       (mm_b),
        .m       (ops.modulus),
        .done    (mm_done),
        .product (mm_product)
    );

    // Multiplier operands follow the current step
    always_comb begin
        mm_a = acc_a;
        mm_b = acc_a;
        case (state)
            S_CONV: begin
                mm_a = ops.x;
                mm_b = ops.rsq;
            end
            S_MUL:   mm_b = xt;
            S_FINAL: mm_b = operand_t'(1);
            default: ;
        endcase
    end

    // Move to the next exponent bit, also while skipping leading zeros
    assign adv = (state == S_SCAN && bits_left != '0 && !e_sh[OPW-1] && !started) ||
                 (state == S_SQR && mm_done && !e_sh[OPW-1]) ||
                 (state == S_MUL && mm_done);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= S_IDLE;
            mm_start     <= 1'b0;
            result_valid <= 1'b0;
            started      <= 1'b0;
            bits_left    <= '0;
        end else begin
            mm_start     <= 1'b0;
            result_valid <= 1'b0;
            if (adv) begin
                bits_left <= bits_left - 1'b1;
            end
            case (state)
                S_IDLE: if (start) begin
                    state     <= S_CONV;
                    mm_start  <= 1'b1;
                    started   <= 1'b0;
                    bits_left <= CW'(OPW);
                end
                S_CONV: if (mm_done) begin
                    result_valid <= mode_r;
                    state        <= mode_r ? S_IDLE : S_SCAN;
                end
                S_SCAN: if (bits_left == '0) begin
                    state    <= S_FINAL;
                    mm_start <= 1'b1;
                end else if (e_sh[OPW-1] || started) begin
                    state    <= S_SQR;
                    mm_start <= 1'b1;
                    started  <= 1'b1;
                end
                S_SQR: if (mm_done) begin
                    state    <= e_sh[OPW-1] ? S_MUL : S_SCAN;
                    mm_start <= e_sh[OPW-1];
                end
                S_MUL:   if (mm_done) state <= S_SCAN;
                S_FINAL: if (mm_done) begin
                    result_valid <= 1'b1;
                    state        <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            mode_r <= mode;
            e_sh   <= ops.exponent;
        end else if (adv) begin
            e_sh <= e_sh << 1;
        end
        if (mm_done) begin
            case (state)
                S_CONV: begin
                    // Base in Montgomery form, A starts as 1 in Montgomery form
                    xt           <= mm_product;
                    acc_a        <= ops.rmodm;
                    result_value <= mm_product;
                end
                S_SQR, S_MUL: acc_a <= mm_product;
                S_FINAL:      result_value <= mm_product;
                default: ;
            endcase
        end
    end

endmodule

/* src/mont_mul.sv */
`timescale 1ns/1ps
`include "rsa_cfg.svh"

module mont_mul import rsa_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    input  operand_t m,
    output logic     done,
    output operand_t product
);

    localparam int OPW = `RSA_OPW;
    localparam int CW  = $clog2(OPW + 1);

    logic           busy;
    logic [CW-1:0]  cnt;
    operand_t       a_sh;
    operand_t       b_r;
    operand_t       m_r;
    logic [OPW:0]   acc;
    logic [OPW:0]   diff;

    // Add b when the a bit is set, make the sum even with m, then halve
    function automatic logic [OPW:0] mont_step(
        input logic [OPW:0] acc_in,
        input logic         a_bit,
        input operand_t     b_val,
        input operand_t     m_val
    );
        logic [OPW+1:0] sum;
        sum = {1'b0, acc_in} + (a_bit ? {2'b00, b_val} : '0);
        if (sum[0]) begin
            sum = sum + {2'b00, m_val};
        end
        return sum[OPW+1:1];
    endfunction

    // acc stays below 2m, so one subtraction is enough at the end
    assign diff = acc - {1'b0, m_r};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CW'(1);
            end else if (busy) begin
                if (cnt == CW'(OPW)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // First step is taken on the start cycle itself
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh <= a >> 1;
            b_r  <= b;
            m_r  <= m;
            acc  <= mont_step('0, a[0], b, m);
        end else if (busy) begin
            if (cnt == CW'(OPW)) begin
                product <= (acc >= {1'b0, m_r}) ? diff[OPW-1:0] : acc[OPW-1:0];
            end else begin
                acc  <= mont_step(acc, a_sh[0], b_r, m_r);
                a_sh <= a_sh >> 1;
            end
        end
    end

endmodule

/* src/operand_bank.sv */
`timescale 1ns/1ps
`include "rsa_cfg.svh"

module operand_bank import rsa_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  load_sel_e     load_sel,
    input  bus_t          data_in,
    input  logic          result_valid,
    input  operand_t      result_value,
    output rsa_operands_t ops,
    output operand_t      result
);

    operand_t lo_half;
    operand_t hi_half;

    assign lo_half = data_in[`RSA_OPW-1:0];
    assign hi_half = data_in[`RSA_BUSW-1:`RSA_OPW];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ops    <= '0;
            result <= '0;
        end else begin
            case (load_sel)
                LOAD_MOD: ops.modulus <= lo_half;
                // R^2 mod m below, base above
                LOAD_RSQ: begin
                    ops.rsq <= lo_half;
                    ops.x   <= hi_half;
                end
                // Exponent below, R mod m above
                LOAD_EXP: begin
                    ops.exponent <= lo_half;
                    ops.rmodm    <= hi_half;
                end
                default: ;
            endcase
            // Last result is held for WRITE_RES
            if (result_valid) begin
                result <= result_value;
            end
        end
    end

endmodule

/* src/rsa_cfg.svh */
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// Width of one RSA operand in bits
`define RSA_OPW 32

// Host data bus carries two operands side by side
`define RSA_BUSW (2 * `RSA_OPW)

// Host command word, opcode sits in bits 2:0
`define RSA_CMDW 32

`endif

/* src/rsa_pkg.sv */
`include "rsa_cfg.svh"

package rsa_pkg;

    typedef logic [`RSA_OPW-1:0] operand_t;

    typedef logic [`RSA_BUSW-1:0] bus_t;

    // Host opcodes, 6 and 7 are not assigned
    typedef enum logic [2:0] {
        COMPUTE_EXP  = 3'd0,
        COMPUTE_MONT = 3'd1,
        READ_MOD     = 3'd2,
        READ_RSQ     = 3'd3,
        READ_EXP     = 3'd4,
        WRITE_RES    = 3'd5
    } cmd_op_e;

    // Which operand registers take the data bus
    typedef enum logic [1:0] {
        LOAD_NONE = 2'd0,
        LOAD_MOD  = 2'd1,
        LOAD_RSQ  = 2'd2,
        LOAD_EXP  = 2'd3
    } load_sel_e;

    // Everything the engine needs for one operation
    typedef struct packed {
        operand_t modulus;
        operand_t rmodm;
        operand_t rsq;
        operand_t exponent;
        operand_t x;
    } rsa_operands_t;

endpackage

/* src/rsa_top.sv */
`timescale 1ns/1ps
`include "rsa_cfg.svh"

module rsa_top import rsa_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [`RSA_CMDW-1:0] cmd,
    input  logic                 cmd_valid,
    input  bus_t                 data_in,
    input  logic                 in_valid,
    output logic                 in_ready,
    output bus_t                 data_out,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 done,
    input  logic                 done_read
);

    load_sel_e     load_sel;
    logic          start;
    logic          mode;
    logic          result_valid;
    operand_t      result_value;
    operand_t      result;
    rsa_operands_t ops;

    cmd_ctrl i_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .in_valid     (in_valid),
        .out_ready    (out_ready),
        .done_read    (done_read),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .done         (done),
        .load_sel     (load_sel),
        .start        (start),
        .mode         (mode),
        .result_valid (result_valid)
    );

    operand_bank i_bank (
        .clk          (clk),
        .resetn       (resetn),
        .load_sel     (load_sel),
        .data_in      (data_in),
        .result_valid (result_valid),
        .result_value (result_value),
        .ops          (ops),
        .result       (result)
    );

    mod_exp i_exp (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .mode         (mode),
        .ops          (ops),
        .result_valid (result_valid),
        .result_value (result_value)
    );

    // Result in the low half, upper half zero
    assign data_out = {{(`RSA_BUSW - `RSA_OPW){1'b0}}, result};

endmodule

/* tests/tb_rsa_top.sv */
`timescale 1ns/1ps
`include "rsa_cfg.svh"

module tb_rsa_top import rsa_pkg::*; ();

    localparam int OPW = `RSA_OPW;
    // One unused opcode, then five commands for every loaded operand set
    localparam int N_OPS = 1 + 5 * (1 + 8 + 3 + 1);
    localparam int LIMIT = 40 * (OPW + 1) * (2 * OPW + 3) * N_OPS;

    logic                 clk;
    logic                 resetn;
    logic [`RSA_CMDW-1:0] cmd;
    logic                 cmd_valid;
    bus_t                 data_in;
    logic                 in_valid;
    logic                 in_ready;
    bus_t                 data_out;
    logic                 out_valid;
    logic                 out_ready;
    logic                 done;
    logic                 done_read;

    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'hcf5b;

    rsa_top i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .data_in   (data_in),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .data_out  (data_out),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .done      (done),
        .done_read (done_read)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: the DUT gave no response within %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

    // Right-shift Galois LFSR with taps x^32 + x^31 + x^29 + x + 1
    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'hd000_0001;
        end
        return lsb;
    endfunction

    function automatic operand_t rand_operand(int nbits);
        operand_t v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[OPW-2:0], next_bit()};
        end
        return v;
    endfunction

    // Odd modulus with the top bit set
    function automatic operand_t rand_modulus();
        operand_t m;
        m = rand_operand(OPW);
        m[0] = 1'b1;
        m[OPW-1] = 1'b1;
        return m;
    endfunction

    // 2^k mod m by repeated doubling
    function automatic operand_t pow2_mod(operand_t m, int k);
        logic [63:0] r;
        r = 64'd1 % 64'(m);
        for (int i = 0; i < k; i++) begin
            r = (r << 1) % 64'(m);
        end
        return operand_t'(r);
    endfunction

    // a*b*2^-OPW mod m by add-and-halve in 64-bit arithmetic
    function automatic operand_t mont_model(operand_t a, operand_t b, operand_t m);
        logic [63:0] acc;
        acc = 64'd0;
        for (int i = 0; i < OPW; i++) begin
            if (a[i]) begin
                acc = acc + 64'(b);
            end
            if (acc[0]) begin
                acc = acc + 64'(m);
            end
            acc = acc >> 1;
        end
        if (acc >= 64'(m)) begin
            acc = acc - 64'(m);
        end
        return operand_t'(acc);
    endfunction

    // Plain x^e mod m
    function automatic operand_t pow_model(operand_t x, operand_t e, operand_t m);
        logic [63:0] res;
        res = 64'd1 % 64'(m);
        for (int i = OPW - 1; i >= 0; i--) begin
            res = (res * res) % 64'(m);
            if (e[i]) begin
                res = (res * 64'(x)) % 64'(m);
            end
        end
        return operand_t'(res);
    endfunction

    task automatic check_operand(string name, operand_t got, operand_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "operand mismatch");
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // One-cycle command strobe
    task automatic issue_cmd(logic [2:0] code);
        cmd = {{(`RSA_CMDW - 3){1'b0}}, code};
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic finish_cmd();
        while (!done) @(negedge clk);
        done_read = 1'b1;
        @(negedge clk);
        done_read = 1'b0;
        check_flag("done", done, 1'b0);
    endtask

    task automatic load_word(cmd_op_e op, bus_t d);
        issue_cmd(op);
        in_valid = 1'b1;
        data_in = d;
        while (!in_ready) @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
        check_flag("in_ready", in_ready, 1'b0);
        finish_cmd();
    endtask

    task automatic load_operands(operand_t m, operand_t x, operand_t e);
        load_word(READ_MOD, {{OPW{1'b0}}, m});
        load_word(READ_RSQ, {x, pow2_mod(m, 2 * OPW)});
        load_word(READ_EXP, {pow2_mod(m, OPW), e});
    endtask

    task automatic run_compute(cmd_op_e op);
        issue_cmd(op);
        finish_cmd();
    endtask

    // Holds out_ready low for stall cycles before taking the word
    task automatic read_result(int stall, operand_t exp);
        bus_t held;
        issue_cmd(WRITE_RES);
        while (!out_valid) @(negedge clk);
        held = data_out;
        repeat (stall) begin
            check_flag("out_valid", out_valid, 1'b1);
            check_flag("done", done, 1'b0);
            check_operand("data_out held", data_out[OPW-1:0], held[OPW-1:0]);
            @(negedge clk);
        end
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
        check_flag("out_valid", out_valid, 1'b0);
        finish_cmd();
        check_operand("data_out low", data_out[OPW-1:0], exp);
        check_operand("data_out high", data_out[`RSA_BUSW-1:OPW], '0);
    endtask

    task automatic run_exp(operand_t m, operand_t x, operand_t e, operand_t exp);
        load_operands(m, x, e);
        run_compute(COMPUTE_EXP);
        read_result(0, exp);
    endtask

    task automatic test_reset_and_unused();
        check_flag("done", done, 1'b0);
        check_flag("in_ready", in_ready, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        issue_cmd(3'd6);
        repeat (20) begin
            check_flag("done", done, 1'b0);
            check_flag("in_ready", in_ready, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic test_mont_product();
        operand_t m;
        operand_t x;
        m = rand_modulus();
        x = rand_operand(OPW) % m;
        load_operands(m, x, rand_operand(OPW));
        run_compute(COMPUTE_MONT);
        read_result(0, mont_model(x, pow2_mod(m, 2 * OPW), m));
    endtask

    task automatic test_random_exp();
        operand_t m;
        operand_t x;
        operand_t e;
        for (int i = 0; i < 8; i++) begin
            m = rand_modulus();
            x = rand_operand(OPW) % m;
            e = rand_operand(OPW);
            run_exp(m, x, e, pow_model(x, e, m));
        end
    endtask

    task automatic test_edge_exponents();
        operand_t m;
        operand_t x;
        m = rand_modulus();
        x = rand_operand(OPW) % m;
        run_exp(m, x, '0, operand_t'(1));
        run_exp(m, x, operand_t'(1), x);
        run_exp(m, x, '1, pow_model(x, '1, m));
    endtask

    task automatic test_backpressure();
        operand_t m;
        operand_t x;
        operand_t e;
        int       stall;
        m = rand_modulus();
        x = rand_operand(OPW) % m;
        e = rand_operand(OPW);
        // Between 1 and 15 stalled cycles
        stall = 1 + int'(rand_operand(4)) % 15;
        load_operands(m, x, e);
        run_compute(COMPUTE_EXP);
        read_result(stall, pow_model(x, e, m));
    endtask

    initial begin
        resetn = 1'b0;
        cmd = '0;
        cmd_valid = 1'b0;
        data_in = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        done_read = 1'b0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        test_reset_and_unused();
        test_mont_product();
        test_random_exp();
        test_edge_exponents();
        test_backpressure();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+src
src/rsa_pkg.sv
src/mont_mul.sv
src/mod_exp.sv
src/operand_bank.sv
src/cmd_ctrl.sv
src/rsa_top.sv
tests/tb_rsa_top.sv
